//--- verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // datapath and cluster sizes.
    localparam int xlen       = 32;
    localparam int num_lanes  = 3;
    localparam int iq_depth   = 8;
    localparam int mul_cycles = 3;
    localparam int rob_num_w  = 6;
    localparam int preg_w     = 6;

    // derived widths.
    localparam int iq_ptr_w   = $clog2(iq_depth);
    localparam int iq_cnt_w   = $clog2(iq_depth + 1);
    localparam int lane_idx_w = $clog2(num_lanes);
    localparam int mul_cnt_w  = $clog2(mul_cycles + 1);

    typedef logic [xlen-1:0]      word_t;
    typedef logic [rob_num_w-1:0] rob_num_t;
    typedef logic [preg_w-1:0]    preg_t;

    // alu operations, all single cycle except op_mul.
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        op_sll  = 4'h5,
        op_srl  = 4'h6,
        op_sra  = 4'h7,
        op_slt  = 4'h8,
        op_sltu = 4'h9,
        op_mul  = 4'ha
    } alu_op_e;

endpackage

`default_nettype wire

//--- verilog/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue import exec_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 dispatch_valid,
    input  alu_op_e              dispatch_op,
    input  word_t                src1_data,
    input  word_t                src2_data,
    input  word_t                imm,
    input  logic                 use_imm,
    input  preg_t                dest_tag,
    input  rob_num_t             rob_num,
    input  logic [num_lanes-1:0] lane_ready,
    output logic                 stall,
    output logic [num_lanes-1:0] issue_valid,
    output alu_op_e              issue_op,
    output word_t                issue_a,
    output word_t                issue_b,
    output preg_t                issue_tag,
    output rob_num_t             issue_rob
);

    // entry storage.
    alu_op_e  q_op      [iq_depth];
    word_t    q_src1    [iq_depth];
    word_t    q_src2    [iq_depth];
    word_t    q_imm     [iq_depth];
    logic     q_use_imm [iq_depth];
    preg_t    q_tag     [iq_depth];
    rob_num_t q_rob     [iq_depth];

    logic [iq_ptr_w-1:0] head;
    logic [iq_ptr_w-1:0] tail;
    logic [iq_cnt_w-1:0] count;
    logic                push;
    logic                pop;

    assign stall = (count == iq_cnt_w'(iq_depth));
    assign push  = dispatch_valid && !stall;
    assign pop   = |issue_valid;

    // oldest entry goes to the lowest ready lane.
    always_comb begin
        issue_valid = '0;
        if (count != '0) begin
            for (int i = 0; i < num_lanes; i++) begin
                if (lane_ready[i] && (issue_valid == '0)) begin
                    issue_valid[i] = 1'b1;
                end
            end
        end
    end

    assign issue_op  = q_op[head];
    assign issue_a   = q_src1[head];
    assign issue_b   = q_use_imm[head] ? q_imm[head] : q_src2[head];
    assign issue_tag = q_tag[head];
    assign issue_rob = q_rob[head];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == iq_ptr_w'(iq_depth - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == iq_ptr_w'(iq_depth - 1)) ? '0 : head + 1'b1;
            end
            // push and pop together leave the count alone.
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_op[tail]      <= dispatch_op;
            q_src1[tail]    <= src1_data;
            q_src2[tail]    <= src2_data;
            q_imm[tail]     <= imm;
            q_use_imm[tail] <= use_imm;
            q_tag[tail]     <= dest_tag;
            q_rob[tail]     <= rob_num;
        end
    end

    // dispatch must respect back-pressure.
    a_no_dispatch_on_stall: assert property (
        @(posedge clk) disable iff (!rstn) dispatch_valid |-> !stall);

    a_one_issue: assert property (
        @(posedge clk) disable iff (!rstn) $onehot0(issue_valid));

endmodule

`default_nettype wire

//--- verilog/alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module alu_lane import exec_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     issue_valid,
    input  alu_op_e  issue_op,
    input  word_t    issue_a,
    input  word_t    issue_b,
    input  preg_t    issue_tag,
    input  rob_num_t issue_rob,
    input  logic     grant,
    output logic     ready,
    output logic     done,
    output word_t    result,
    output preg_t    done_tag,
    output rob_num_t done_rob
);

    logic                 busy;
    logic [mul_cnt_w-1:0] mul_cnt;
    logic                 mul_last;
    word_t                a_q;
    word_t                b_q;

    function automatic word_t alu_calc(alu_op_e op, word_t a, word_t b);
        word_t r;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_sll:  r = a << b[4:0];
            op_srl:  r = a >> b[4:0];
            op_sra:  r = word_t'($signed(a) >>> b[4:0]);
            op_slt:  r = word_t'($signed(a) < $signed(b));
            op_sltu: r = word_t'(a < b);
            op_mul:  r = a * b;
            default: r = '0;
        endcase
        return r;
    endfunction

    // a held result blocks new work until granted.
    assign ready    = !busy && !done;
    assign mul_last = busy && (mul_cnt == mul_cnt_w'(1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            mul_cnt <= '0;
        end else begin
            if (done && grant) begin
                done <= 1'b0;
            end
            if (issue_valid) begin
                if (issue_op == op_mul) begin
                    busy    <= 1'b1;
                    mul_cnt <= mul_cnt_w'(mul_cycles - 1);
                end else begin
                    done <= 1'b1;
                end
            end else if (mul_last) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else if (busy) begin
                mul_cnt <= mul_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            a_q      <= issue_a;
            b_q      <= issue_b;
            done_tag <= issue_tag;
            done_rob <= issue_rob;
            if (issue_op != op_mul) begin
                result <= alu_calc(issue_op, issue_a, issue_b);
            end
        end else if (mul_last) begin
            result <= alu_calc(op_mul, a_q, b_q);
        end
    end

    a_issue_when_ready: assert property (
        @(posedge clk) disable iff (!rstn) issue_valid |-> ready);

    // result must not move while waiting on the arbiter.
    a_hold_until_grant: assert property (
        @(posedge clk) disable iff (!rstn)
        done && !grant |=> done && $stable(result) && $stable(done_rob));

endmodule

`default_nettype wire

//--- verilog/completion_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module completion_arbiter import exec_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [num_lanes-1:0] done,
    input  word_t                result   [num_lanes],
    input  preg_t                done_tag [num_lanes],
    input  rob_num_t             done_rob [num_lanes],
    output logic [num_lanes-1:0] grant,
    output logic                 complete_valid,
    output word_t                complete_data,
    output preg_t                complete_tag,
    output rob_num_t             complete_rob
);

    // lane with first claim this cycle.
    logic [lane_idx_w-1:0] rr_ptr;
    logic [lane_idx_w-1:0] sel_idx;
    int                    cand;

    always_comb begin
        grant   = '0;
        sel_idx = '0;
        cand    = 0;
        for (int k = 0; k < num_lanes; k++) begin
            cand = (int'(rr_ptr) + k) % num_lanes;
            if (done[cand] && (grant == '0)) begin
                grant[cand] = 1'b1;
                sel_idx     = lane_idx_w'(cand);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rr_ptr         <= '0;
            complete_valid <= 1'b0;
        end else begin
            complete_valid <= |grant;
            if (|grant) begin
                rr_ptr <= (sel_idx == lane_idx_w'(num_lanes - 1)) ? '0 : sel_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|grant) begin
            complete_data <= result[sel_idx];
            complete_tag  <= done_tag[sel_idx];
            complete_rob  <= done_rob[sel_idx];
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rstn) $onehot0(grant));

endmodule

`default_nettype wire

//--- verilog/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster import exec_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     dispatch_valid,
    input  alu_op_e  dispatch_op,
    input  word_t    src1_data,
    input  word_t    src2_data,
    input  word_t    imm,
    input  logic     use_imm,
    input  preg_t    dest_tag,
    input  rob_num_t rob_num,
    output logic     stall,
    output logic     complete_valid,
    output word_t    complete_data,
    output preg_t    complete_tag,
    output rob_num_t complete_rob
);

    // queue to lanes.
    logic [num_lanes-1:0] lane_ready;
    logic [num_lanes-1:0] issue_valid;
    alu_op_e              issue_op;
    word_t                issue_a;
    word_t                issue_b;
    preg_t                issue_tag;
    rob_num_t             issue_rob;

    // lanes to arbiter.
    logic [num_lanes-1:0] lane_done;
    logic [num_lanes-1:0] lane_grant;
    word_t                lane_result [num_lanes];
    preg_t                lane_tag    [num_lanes];
    rob_num_t             lane_rob    [num_lanes];

    issue_queue u_issue_queue (
        .clk            (clk),
        .rstn           (rstn),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .src1_data      (src1_data),
        .src2_data      (src2_data),
        .imm            (imm),
        .use_imm        (use_imm),
        .dest_tag       (dest_tag),
        .rob_num        (rob_num),
        .lane_ready     (lane_ready),
        .stall          (stall),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_a        (issue_a),
        .issue_b        (issue_b),
        .issue_tag      (issue_tag),
        .issue_rob      (issue_rob)
    );

    // each lane sees the shared issue fields and its own strobe.
    for (genvar i = 0; i < num_lanes; i++) begin : gen_lane
        alu_lane u_alu_lane (
            .clk         (clk),
            .rstn        (rstn),
            .issue_valid (issue_valid[i]),
            .issue_op    (issue_op),
            .issue_a     (issue_a),
            .issue_b     (issue_b),
            .issue_tag   (issue_tag),
            .issue_rob   (issue_rob),
            .grant       (lane_grant[i]),
            .ready       (lane_ready[i]),
            .done        (lane_done[i]),
            .result      (lane_result[i]),
            .done_tag    (lane_tag[i]),
            .done_rob    (lane_rob[i])
        );
    end

    completion_arbiter u_completion_arbiter (
        .clk            (clk),
        .rstn           (rstn),
        .done           (lane_done),
        .result         (lane_result),
        .done_tag       (lane_tag),
        .done_rob       (lane_rob),
        .grant          (lane_grant),
        .complete_valid (complete_valid),
        .complete_data  (complete_data),
        .complete_tag   (complete_tag),
        .complete_rob   (complete_rob)
    );

endmodule

`default_nettype wire

//--- tests/tb_exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster import exec_pkg::*; ();

    localparam int  num_cases       = 24;
    localparam int  fields          = 6;
    localparam int  total_ops       = 64;
    localparam int  watchdog_cycles = total_ops * (mul_cycles + 4) * 4 + 100;
    localparam time clk_period      = 100;

    logic     clk;
    logic     rstn;
    logic     dispatch_valid;
    alu_op_e  dispatch_op;
    word_t    src1_data;
    word_t    src2_data;
    word_t    imm;
    logic     use_imm;
    preg_t    dest_tag;
    rob_num_t rob_num;
    logic     stall;
    logic     complete_valid;
    word_t    complete_data;
    preg_t    complete_tag;
    rob_num_t complete_rob;

    // case file columns: opcode, src1, src2, imm, use_imm, expected.
    word_t cases_mem [num_cases*fields];

    // scoreboard, indexed by rob number.
    word_t exp_data [total_ops];
    preg_t exp_tag  [total_ops];
    bit    sent     [total_ops];
    int    seen     [total_ops];

    int          mul_idx[$];
    logic [31:0] lfsr_state;
    int          value_errors;
    int          other_errors;
    int          completions;
    bit          stall_seen;

    exec_cluster u_exec_cluster (
        .clk            (clk),
        .rstn           (rstn),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .src1_data      (src1_data),
        .src2_data      (src2_data),
        .imm            (imm),
        .use_imm        (use_imm),
        .dest_tag       (dest_tag),
        .rob_num        (rob_num),
        .stall          (stall),
        .complete_valid (complete_valid),
        .complete_data  (complete_data),
        .complete_tag   (complete_tag),
        .complete_rob   (complete_rob)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input preg_t got, input preg_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_rob(input rob_num_t got, output bit known);
        known = 1'b0;
        if (!sent[got]) begin
            other_errors++;
            $display("completion carries rob %0d, which was never dispatched", got);
        end else if (seen[got] != 0) begin
            other_errors++;
            $display("rob %0d completed more than once", got);
        end else begin
            known = 1'b1;
        end
        seen[got]++;
    endtask

    // called a small delay after a rising edge, and returns at the same point.
    task automatic dispatch_case(input int idx, input int rob);
        int base;
        base = idx * fields;
        while (stall) begin
            stall_seen = 1'b1;
            @(posedge clk);
            #1;
        end
        exp_data[rob]  = cases_mem[base+5];
        exp_tag[rob]   = preg_t'(rob) ^ preg_t'(6'h2a);
        sent[rob]      = 1'b1;
        dispatch_valid = 1'b1;
        dispatch_op    = alu_op_e'(cases_mem[base][3:0]);
        src1_data      = cases_mem[base+1];
        src2_data      = cases_mem[base+2];
        imm            = cases_mem[base+3];
        use_imm        = cases_mem[base+4][0];
        dest_tag       = exp_tag[rob];
        rob_num        = rob_num_t'(rob);
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
    endtask

    // completion monitor.
    always @(negedge clk) begin
        bit known;
        if (rstn && complete_valid) begin
            completions++;
            check_rob(complete_rob, known);
            if (known) begin
                check_word($sformatf("complete_data rob %0d", complete_rob),
                           complete_data, exp_data[complete_rob]);
                check_tag($sformatf("complete_tag rob %0d", complete_rob),
                          complete_tag, exp_tag[complete_rob]);
            end
        end
    end

    initial begin
        int gap;
        int rob;
        rstn           = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = op_add;
        src1_data      = '0;
        src2_data      = '0;
        imm            = '0;
        use_imm        = 1'b0;
        dest_tag       = '0;
        rob_num        = '0;
        lfsr_state     = 32'h0aac_60cc;
        value_errors   = 0;
        other_errors   = 0;
        completions    = 0;
        stall_seen     = 1'b0;
        for (int r = 0; r < total_ops; r++) begin
            sent[r]     = 1'b0;
            seen[r]     = 0;
            exp_data[r] = '0;
            exp_tag[r]  = '0;
        end
        $readmemh("tests/exec_cases.mem", cases_mem);
        for (int i = 0; i < num_cases; i++) begin
            if (cases_mem[i*fields][3:0] == op_mul) begin
                mul_idx.push_back(i);
            end
        end

        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;
        check_flag("stall", stall, 1'b0);
        check_flag("complete_valid", complete_valid, 1'b0);

        // every case once, with random gaps.
        rob = 0;
        for (int i = 0; i < num_cases; i++) begin
            draw_bits(2, gap);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            dispatch_case(i, rob);
            rob++;
        end

        // back-to-back multiplies outrun the lanes and fill the queue.
        while (rob < total_ops) begin
            dispatch_case(mul_idx[(rob - num_cases) % mul_idx.size()], rob);
            rob++;
        end
        if (!stall_seen) begin
            other_errors++;
            $display("stall never rose during the multiply burst");
        end

        while (completions < total_ops) @(posedge clk);
        repeat (8) @(posedge clk);
        for (int r = 0; r < total_ops; r++) begin
            if (seen[r] == 0) begin
                other_errors++;
                $display("rob %0d was dispatched but never completed", r);
            end
        end

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles with %0d of %0d completions seen",
                 watchdog_cycles, completions, total_ops);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/exec_cases.mem
// columns: opcode src1 src2 imm use_imm expected
// opcodes: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 sra 8 slt 9 sltu a mul
0 00000005 00000007 00000000 0 0000000c
0 7fffffff 11111111 00000001 1 80000000
1 00000003 00000005 00000000 0 fffffffe
1 00000010 deadbeef 00000010 1 00000000
2 f0f0f0f0 ff00ff00 00000000 0 f000f000
2 12345678 00ff0000 0000ffff 1 00005678
3 0f0f0000 000000f0 00000000 0 0f0f00f0
3 80000000 00000100 00000001 1 80000001
4 aaaaaaaa 55555555 00000000 0 ffffffff
4 12345678 0000000f ffffffff 1 edcba987
a 00012345 00006789 00000000 0 75cca2ed
5 00000001 0000001f 00000000 0 80000000
5 0000000f 00000001 00000024 1 000000f0
6 80000000 0000001f 00000000 0 00000001
6 f0000000 00000010 00000004 1 0f000000
a ffffffff 00000003 00000000 0 fffffffd
7 80000000 00000004 00000000 0 f8000000
7 7ffffff0 00000001 00000004 1 07ffffff
8 ffffffff 00000001 00000000 0 00000001
8 00000005 00000009 fffffffb 1 00000000
9 ffffffff 00000001 00000000 0 00000000
9 00000001 00000000 ffffffff 1 00000001
a 00010000 00000002 00010000 1 00000000
a 0000abcd 00001000 00000000 0 0abcd000

//--- exec_cluster.f
verilog/exec_pkg.sv
verilog/issue_queue.sv
verilog/alu_lane.sv
verilog/completion_arbiter.sv
verilog/exec_cluster.sv
tests/tb_exec_cluster.sv

//--- Bender.yml
package:
  name: exec_cluster

sources:
  - verilog/exec_pkg.sv
  - verilog/issue_queue.sv
  - verilog/alu_lane.sv
  - verilog/completion_arbiter.sv
  - verilog/exec_cluster.sv
  - target: test
    files:
      - tests/tb_exec_cluster.sv
